//--- rtl/lane_rx_detect.sv
`timescale 1ns/1ps
`include "pcie_phy_consts.svh"

module lane_rx_detect (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       start_i,
  input  logic       phystatus_i,
  input  logic [2:0] rxstatus_i,
  output logic       txdetectrx_o,
  output logic       done_o,
  output logic       present_o
);

  typedef enum logic [1:0] {
    LN_IDLE,
    LN_DETECTING,
    LN_DONE
  } lane_st_e;

  lane_st_e state_r;
  logic     present_r;

  always_ff @(posedge clk_i or posedge rst_i) begin : lane_seq
    if (rst_i) begin
      state_r   <= LN_IDLE;
      present_r <= 1'b0;
    end else begin
      case (state_r)
        LN_IDLE: begin
          if (start_i) begin
            state_r   <= LN_DETECTING;
            present_r <= 1'b0;
          end
        end

        LN_DETECTING: begin
          if (start_i) begin
            // restart drops the pending answer
            present_r <= 1'b0;
          end else if (phystatus_i) begin
            state_r   <= LN_DONE;
            present_r <= (rxstatus_i == `PCIE_RXSTATUS_PRESENT);
          end
        end

        LN_DONE: begin
          if (start_i) begin
            state_r   <= LN_DETECTING;
            present_r <= 1'b0;
          end
        end

        default: begin
          state_r <= LN_IDLE;
        end
      endcase
    end
  end

  // strobe stays up until the PHY answers
  assign txdetectrx_o = (state_r == LN_DETECTING);
  assign done_o       = (state_r == LN_DONE);
  assign present_o    = present_r;

endmodule

//--- rtl/link_width_resolve.sv
`timescale 1ns/1ps
`include "pcie_phy_consts.svh"

module link_width_resolve
  import pcie_phy_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       detect_ok_i,
  input  logic [`PCIE_NUM_LANES-1:0] final_mask_i,
  output link_width_e                link_width_o,
  output logic                       link_up_o
);

  link_width_e width_c;
  link_width_e width_r;
  logic        link_up_r;

  // widest run of lanes starting at lane 0
  always_comb begin : width_comb
    if (&final_mask_i[3:0]) begin
      width_c = LW_X4;
    end else if (&final_mask_i[1:0]) begin
      width_c = LW_X2;
    end else if (final_mask_i[0]) begin
      width_c = LW_X1;
    end else begin
      width_c = LW_NONE;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin : width_seq
    if (rst_i) begin
      width_r   <= LW_NONE;
      link_up_r <= 1'b0;
    end else if (detect_ok_i) begin
      width_r   <= width_c;
      link_up_r <= (width_c != LW_NONE);
    end else begin
      width_r   <= LW_NONE;
      link_up_r <= 1'b0;
    end
  end

  assign link_width_o = width_r;
  assign link_up_o    = link_up_r;

endmodule

//--- rtl/ltssm_detect.sv
`timescale 1ns/1ps
`include "pcie_phy_consts.svh"

module ltssm_detect
  import pcie_phy_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       en_i,
  input  logic [`PCIE_NUM_LANES-1:0] rx_active_i,
  input  logic [`PCIE_NUM_LANES-1:0] lane_done_i,
  input  logic [`PCIE_NUM_LANES-1:0] lane_present_i,
  output logic [`PCIE_NUM_LANES-1:0] lane_start_o,
  output logic                       detect_ok_o,
  output logic                       detect_fail_o,
  output logic [`PCIE_NUM_LANES-1:0] final_mask_o,
  output logic [`PCIE_NUM_LANES-1:0] lane_elec_idle_o
);

  detect_st_e curr_state, next_state;

  logic [31:0]                timer_c, timer_r;
  logic [`PCIE_NUM_LANES-1:0] start_c, start_r;
  logic [`PCIE_NUM_LANES-1:0] first_mask_c, first_mask_r;
  logic [`PCIE_NUM_LANES-1:0] mask_c, mask_r;
  logic [`PCIE_NUM_LANES-1:0] idle_c, idle_r;
  logic                       ok_c, ok_r;
  logic                       fail_c, fail_r;
  logic                       all_done;

  // done bits are stale while a start pulse is still out
  assign all_done = (&lane_done_i) && !(|start_r);

  always_ff @(posedge clk_i or posedge rst_i) begin : detect_seq
    if (rst_i) begin
      curr_state   <= ST_IDLE;
      timer_r      <= '0;
      start_r      <= '0;
      first_mask_r <= '0;
      mask_r       <= '0;
      idle_r       <= '1;
      ok_r         <= 1'b0;
      fail_r       <= 1'b0;
    end else begin
      curr_state   <= next_state;
      timer_r      <= timer_c;
      start_r      <= start_c;
      first_mask_r <= first_mask_c;
      mask_r       <= mask_c;
      idle_r       <= idle_c;
      ok_r         <= ok_c;
      fail_r       <= fail_c;
    end
  end

  always_comb begin : detect_comb
    next_state   = curr_state;
    timer_c      = timer_r;
    start_c      = '0;
    first_mask_c = first_mask_r;
    mask_c       = mask_r;
    idle_c       = idle_r;
    ok_c         = ok_r;
    fail_c       = fail_r;

    if (!en_i) begin
      // release of enable aborts any step and clears results
      next_state   = ST_IDLE;
      timer_c      = '0;
      first_mask_c = '0;
      mask_c       = '0;
      idle_c       = '1;
      ok_c         = 1'b0;
      fail_c       = 1'b0;
    end else begin
      case (curr_state)
        ST_IDLE: begin
          timer_c    = '0;
          next_state = ST_DETECT_QUIET;
        end

        ST_DETECT_QUIET: begin
          timer_c = timer_r + 32'd1;
          // early exit once the far end shows activity
          if ((|rx_active_i) || (timer_r >= `PCIE_QUIET_CYCLES - 32'd1)) begin
            timer_c    = '0;
            start_c    = '1;
            next_state = ST_DETECT_ACTIVE;
          end
        end

        ST_DETECT_ACTIVE: begin
          if (all_done) begin
            if (&lane_present_i) begin
              mask_c     = lane_present_i;
              idle_c     = ~lane_present_i;
              ok_c       = 1'b1;
              next_state = ST_WAIT_EN_LOW;
            end else if (!(|lane_present_i)) begin
              fail_c     = 1'b1;
              next_state = ST_WAIT_EN_LOW;
            end else begin
              // partial answer, keep it and try once more
              first_mask_c = lane_present_i;
              timer_c      = '0;
              next_state   = ST_DETECT_WAIT;
            end
          end
        end

        ST_DETECT_WAIT: begin
          timer_c = timer_r + 32'd1;
          if (timer_r >= `PCIE_DETECT_WAIT_CYCLES - 32'd1) begin
            timer_c    = '0;
            start_c    = '1;
            next_state = ST_DETECT_RX;
          end
        end

        ST_DETECT_RX: begin
          if (all_done) begin
            if (lane_present_i == first_mask_r) begin
              mask_c = lane_present_i;
              idle_c = ~lane_present_i;
              ok_c   = 1'b1;
            end else begin
              fail_c = 1'b1;
            end
            next_state = ST_WAIT_EN_LOW;
          end
        end

        ST_WAIT_EN_LOW: begin
          // verdict holds until enable drops
          next_state = ST_WAIT_EN_LOW;
        end

        default: begin
          next_state = ST_IDLE;
        end
      endcase
    end
  end

  assign lane_start_o     = start_r;
  assign detect_ok_o      = ok_r;
  assign detect_fail_o    = fail_r;
  assign final_mask_o     = mask_r;
  assign lane_elec_idle_o = idle_r;

endmodule

//--- rtl/pcie_detect_top.sv
`timescale 1ns/1ps
`include "pcie_phy_consts.svh"

module pcie_detect_top
  import pcie_phy_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         en_i,
  input  logic [`PCIE_NUM_LANES-1:0]   rx_active_i,
  input  logic [`PCIE_NUM_LANES-1:0]   phystatus_i,
  input  logic [3*`PCIE_NUM_LANES-1:0] rxstatus_i,
  output logic [`PCIE_NUM_LANES-1:0]   txdetectrx_o,
  output logic [`PCIE_NUM_LANES-1:0]   lane_detected_o,
  output logic [`PCIE_NUM_LANES-1:0]   lane_elec_idle_o,
  output logic                         detect_fail_o,
  output link_width_e                  link_width_o,
  output logic                         link_up_o
);

  logic [`PCIE_NUM_LANES-1:0] lane_start;
  logic [`PCIE_NUM_LANES-1:0] lane_done;
  logic [`PCIE_NUM_LANES-1:0] lane_present;
  logic [`PCIE_NUM_LANES-1:0] final_mask;
  logic                       detect_ok;

  ltssm_detect u_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .en_i             (en_i),
    .rx_active_i      (rx_active_i),
    .lane_done_i      (lane_done),
    .lane_present_i   (lane_present),
    .lane_start_o     (lane_start),
    .detect_ok_o      (detect_ok),
    .detect_fail_o    (detect_fail_o),
    .final_mask_o     (final_mask),
    .lane_elec_idle_o (lane_elec_idle_o)
  );

  // one detect sequencer per lane, each with its own rxstatus slice
  for (genvar g = 0; g < `PCIE_NUM_LANES; g++) begin : g_lane
    lane_rx_detect u_lane (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (lane_start[g]),
      .phystatus_i  (phystatus_i[g]),
      .rxstatus_i   (rxstatus_i[3*g +: 3]),
      .txdetectrx_o (txdetectrx_o[g]),
      .done_o       (lane_done[g]),
      .present_o    (lane_present[g])
    );
  end

  link_width_resolve u_resolve (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .detect_ok_i  (detect_ok),
    .final_mask_i (final_mask),
    .link_width_o (link_width_o),
    .link_up_o    (link_up_o)
  );

  assign lane_detected_o = final_mask;

endmodule

//--- rtl/pcie_phy_consts.svh
`ifndef PCIE_PHY_CONSTS_SVH
`define PCIE_PHY_CONSTS_SVH

// lanes on this PHY interface
`define PCIE_NUM_LANES 4

// Detect.Quiet time-out in clocks, scaled down for simulation
`define PCIE_QUIET_CYCLES 32'd40

// pause between first and second detect pass
`define PCIE_DETECT_WAIT_CYCLES 32'd24

// PIPE rxstatus code for receiver present
`define PCIE_RXSTATUS_PRESENT 3'b011

`endif

//--- rtl/pcie_phy_pkg.sv
package pcie_phy_pkg;

  // detect controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DETECT_QUIET,
    ST_DETECT_ACTIVE,
    ST_DETECT_WAIT,
    ST_DETECT_RX,
    ST_WAIT_EN_LOW
  } detect_st_e;

  // negotiated link width
  typedef enum logic [2:0] {
    LW_NONE,
    LW_X1,
    LW_X2,
    LW_X4
  } link_width_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the receiver-detect testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f verilog.f \
  --top-module tb_pcie_detect \
  -o tb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output="$(./obj_dir/tb_sim 2>&1)"
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q "Testbench passed"; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

//--- tests/tb_pcie_detect.sv
`timescale 1ns/1ps
`include "pcie_phy_consts.svh"

module tb_pcie_detect
  import pcie_phy_pkg::*;
();

  localparam int NUM_LANES = `PCIE_NUM_LANES;
  localparam int NUM_ROWS = 9;
  localparam int MAX_PHY_DELAY = 8;
  localparam int TIMEOUT_CYCLES = NUM_ROWS *
    (`PCIE_QUIET_CYCLES + `PCIE_DETECT_WAIT_CYCLES + 2 * MAX_PHY_DELAY + 20) * 2;
  localparam logic [NUM_LANES-1:0] EARLY_PULSE = {{(NUM_LANES-1){1'b0}}, 1'b1};

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     en_i;
  logic [NUM_LANES-1:0]     rx_active_i;
  logic [NUM_LANES-1:0]     phystatus_i = '0;
  logic [3*NUM_LANES-1:0]   rxstatus_i = '0;
  logic [NUM_LANES-1:0]     txdetectrx_o;
  logic [NUM_LANES-1:0]     lane_detected_o;
  logic [NUM_LANES-1:0]     lane_elec_idle_o;
  logic                     detect_fail_o;
  link_width_e              link_width_o;
  logic                     link_up_o;

  // stimulus table with the masks of both passes and early rx activity
  logic [NUM_LANES-1:0] row_first [NUM_ROWS];
  logic [NUM_LANES-1:0] row_second [NUM_ROWS];
  logic                 row_early [NUM_ROWS];
  logic [NUM_LANES-1:0] cur_first;
  logic [NUM_LANES-1:0] cur_second;

  // PHY model state per lane
  int   wait_cnt [NUM_LANES];
  int   pass_cnt [NUM_LANES];
  logic armed [NUM_LANES];
  int   cycle_count = 0;

  always #50 clk_i = ~clk_i;

  pcie_detect_top UUT (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .en_i             (en_i),
    .rx_active_i      (rx_active_i),
    .phystatus_i      (phystatus_i),
    .rxstatus_i       (rxstatus_i),
    .txdetectrx_o     (txdetectrx_o),
    .lane_detected_o  (lane_detected_o),
    .lane_elec_idle_o (lane_elec_idle_o),
    .detect_fail_o    (detect_fail_o),
    .link_width_o     (link_width_o),
    .link_up_o        (link_up_o)
  );

  task automatic set_row(input int r, input logic [NUM_LANES-1:0] first,
                         input logic [NUM_LANES-1:0] second, input logic early);
    row_first[r]  = first;
    row_second[r] = second;
    row_early[r]  = early;
  endtask

  task automatic load_table();
    set_row(0, 4'b1111, 4'b1111, 1'b0);
    set_row(1, 4'b0011, 4'b0011, 1'b0);
    set_row(2, 4'b0101, 4'b0101, 1'b1);
    set_row(3, 4'b0011, 4'b0001, 1'b0);
    set_row(4, 4'b0000, 4'b0000, 1'b0);
    set_row(5, 4'b1110, 4'b1110, 1'b0);
    set_row(6, 4'b1111, 4'b1111, 1'b1);
    set_row(7, 4'b0111, 4'b0111, 1'b0);
    set_row(8, 4'b1011, 4'b0011, 1'b1);
  endtask

  // contiguous lanes counted up from lane 0
  function automatic link_width_e lanes_to_width(input logic [NUM_LANES-1:0] mask);
    int run;
    run = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (mask[l] && run == l) begin
        run = l + 1;
      end
    end
    if (run >= 4) return LW_X4;
    else if (run >= 2) return LW_X2;
    else if (run >= 1) return LW_X1;
    else return LW_NONE;
  endfunction

  function automatic logic [2:0] lane_answer(input int lane, input int pass);
    logic [NUM_LANES-1:0] mask;
    mask = (pass > 1) ? cur_second : cur_first;
    if (mask[lane]) return `PCIE_RXSTATUS_PRESENT;
    else return 3'b000;
  endfunction

  task automatic check_width(input string name, input link_width_e exp_val,
                             input link_width_e act_val);
    if (act_val !== exp_val) begin
      $display("ERR %0t: %s expected %s, got %s", $time, name, exp_val.name(),
               act_val.name());
      $display("Testbench failed");
      $fatal(1, "width mismatch on %s", name);
    end
  endtask

  task automatic check_mask(input string name, input logic [NUM_LANES-1:0] exp_val,
                            input logic [NUM_LANES-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("ERR %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
      $display("Testbench failed");
      $fatal(1, "mask mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("ERR %0t: %s expected %b, got %b", $time, name, exp_val, act_val);
      $display("Testbench failed");
      $fatal(1, "bit mismatch on %s", name);
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("ERR %0t: %s expected %0d, got %0d", $time, name, exp_val, act_val);
      $display("Testbench failed");
      $fatal(1, "count mismatch on %s", name);
    end
  endtask

  task automatic check_idle_outputs();
    check_mask("txdetectrx_o", '0, txdetectrx_o);
    check_mask("lane_detected_o", '0, lane_detected_o);
    check_mask("lane_elec_idle_o", '1, lane_elec_idle_o);
    check_bit("detect_fail_o", 1'b0, detect_fail_o);
    check_bit("link_up_o", 1'b0, link_up_o);
    check_width("link_width_o", LW_NONE, link_width_o);
  endtask

  // answers each txdetectrx after a random delay
  always @(posedge clk_i) begin : phy_model
    for (int l = 0; l < NUM_LANES; l++) begin
      phystatus_i[l] <= 1'b0;
      if (!en_i) begin
        armed[l]    <= 1'b0;
        wait_cnt[l] <= 0;
        pass_cnt[l] <= 0;
      end else if (!txdetectrx_o[l]) begin
        armed[l] <= 1'b0;
      end else if (!armed[l]) begin
        armed[l]    <= 1'b1;
        wait_cnt[l] <= int'($urandom % MAX_PHY_DELAY) + 1;
        pass_cnt[l] <= pass_cnt[l] + 1;
      end else if (wait_cnt[l] > 1) begin
        wait_cnt[l] <= wait_cnt[l] - 1;
      end else if (wait_cnt[l] == 1) begin
        wait_cnt[l]           <= 0;
        phystatus_i[l]        <= 1'b1;
        rxstatus_i[3*l +: 3]  <= lane_answer(l, pass_cnt[l]);
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles, controller in %s", cycle_count,
               UUT.u_ctrl.curr_state.name());
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  task automatic run_row(input int r);
    logic [NUM_LANES-1:0] exp_mask;
    logic                 exp_ok;
    logic                 two_pass;
    logic                 verdict_seen;
    link_width_e          exp_width;
    int                   n;
    int                   first_tx_cycle;
    int                   exp_first_tx;
    int                   pulse_at;
    two_pass  = (row_first[r] != '1) && (row_first[r] != '0);
    exp_ok    = (row_first[r] == '1) || (two_pass && row_second[r] == row_first[r]);
    exp_mask  = exp_ok ? row_first[r] : '0;
    exp_width = exp_ok ? lanes_to_width(exp_mask) : LW_NONE;
    pulse_at  = int'($urandom % 10) + 3;
    // quiet starts one clock after en_i and strobes rise one clock after the start pulse
    exp_first_tx = row_early[r] ? pulse_at + 3 : int'(`PCIE_QUIET_CYCLES) + 2;
    cur_first  = row_first[r];
    cur_second = row_second[r];
    @(posedge clk_i);
    en_i <= 1'b1;
    n = 0;
    first_tx_cycle = -1;
    verdict_seen = 1'b0;
    while (!verdict_seen) begin
      @(posedge clk_i);
      rx_active_i <= (row_early[r] && n == pulse_at) ? EARLY_PULSE : '0;
      @(negedge clk_i);
      n++;
      if (first_tx_cycle < 0 && (|txdetectrx_o)) begin
        first_tx_cycle = n;
      end
      verdict_seen = detect_fail_o || (|lane_detected_o) || link_up_o;
    end
    check_count("first txdetectrx cycle", exp_first_tx, first_tx_cycle);
    // resolver still one clock behind at the verdict
    check_bit("detect_fail_o", !exp_ok, detect_fail_o);
    check_mask("lane_detected_o", exp_mask, lane_detected_o);
    check_mask("lane_elec_idle_o", ~exp_mask, lane_elec_idle_o);
    check_bit("link_up_o", 1'b0, link_up_o);
    check_width("link_width_o", LW_NONE, link_width_o);
    @(posedge clk_i);
    rx_active_i <= '0;
    @(negedge clk_i);
    check_width("link_width_o", exp_width, link_width_o);
    check_bit("link_up_o", exp_ok && exp_width != LW_NONE, link_up_o);
    for (int l = 0; l < NUM_LANES; l++) begin
      check_count($sformatf("lane %0d detect passes", l), two_pass ? 2 : 1, pass_cnt[l]);
    end
    repeat (3) @(negedge clk_i);
    check_bit("detect_fail_o held", !exp_ok, detect_fail_o);
    check_mask("lane_detected_o held", exp_mask, lane_detected_o);
    check_mask("lane_elec_idle_o held", ~exp_mask, lane_elec_idle_o);
    check_width("link_width_o held", exp_width, link_width_o);
    check_bit("link_up_o held", exp_ok && exp_width != LW_NONE, link_up_o);
    @(posedge clk_i);
    en_i <= 1'b0;
    @(negedge clk_i);
    while (detect_fail_o || (|lane_detected_o)) begin
      @(negedge clk_i);
    end
    // resolver clears one clock after the controller
    @(negedge clk_i);
    check_idle_outputs();
  endtask

  initial begin : main
    int seed_value;
    seed_value  = $urandom(32'h2098_1f11);
    rst_i       = 1'b1;
    en_i        = 1'b0;
    rx_active_i = '0;
    cur_first   = '0;
    cur_second  = '0;
    load_table();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_idle_outputs();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/pcie_phy_pkg.sv
rtl/ltssm_detect.sv
rtl/lane_rx_detect.sv
rtl/link_width_resolve.sv
rtl/pcie_detect_top.sv
tests/tb_pcie_detect.sv
